// ==== design/fmul_pkg.sv ====
`default_nettype none

package fmul_pkg;

	// binary32 format constants, sized to the internal exponent width
	localparam logic signed [9:0] FMUL_EXP_BIAS = 10'sd127;
	localparam logic signed [9:0] FMUL_EXP_MIN  = -10'sd126; // Smallest normal exponent
	localparam logic signed [9:0] FMUL_EXP_MAX  = 10'sd127;  // Largest finite exponent
	localparam logic [7:0]        FMUL_EXP_ALL1 = 8'hFF;     // Inf and NaN field

	// Right shift limit on underflow. Further bits all land in sticky
	localparam logic signed [9:0] FMUL_DENORM_SHIFT_MAX = 10'sd26;

	localparam logic [31:0] FMUL_QNAN = 32'hFFC00000;

	// Result class, decided once in stage 1
	typedef enum logic [1:0] {
		CLS_NORMAL,
		CLS_ZERO,
		CLS_INF,
		CLS_NAN
	} fmul_class_e;

	typedef struct packed {
		logic              sign;
		logic signed [9:0] exp;  // Unbiased
		logic [23:0]       mant; // Hidden bit included
	} fmul_operand_t;

	// Stage 1 and stage 2 output
	typedef struct packed {
		logic          valid;
		fmul_class_e   cls;
		logic          sign; // Result sign
		fmul_operand_t a;
		fmul_operand_t b;
	} fmul_unpack_t;

	// Stage 3 output
	typedef struct packed {
		logic              valid;
		fmul_class_e       cls;
		logic              sign;
		logic signed [9:0] exp;
		logic [47:0]       mant; // Full product
	} fmul_prod_t;

	// Stage 4 output
	typedef struct packed {
		logic              valid;
		fmul_class_e       cls;
		logic              sign;
		logic signed [9:0] exp;
		logic [23:0]       mant; // Rounded
	} fmul_round_t;

endpackage

`default_nettype wire

// ==== design/fmul_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_unpack (
	input  logic                   clk,
	input  logic                   round_bit,
	input  logic                   in_valid,
	input  logic [31:0]            a,
	input  logic [31:0]            b,
	output fmul_pkg::fmul_unpack_t out
);
	import fmul_pkg::*;

	logic a_zero, b_zero;
	logic a_inf, b_inf;
	logic a_nan, b_nan;
	fmul_class_e cls;
	fmul_operand_t op_a, op_b;

	function automatic fmul_operand_t split(input logic [31:0] x);
		fmul_operand_t op;
		op.sign = x[31];
		if (x[30:23] == 8'd0) begin
			op.exp  = FMUL_EXP_MIN; // Subnormal or zero
			op.mant = {1'b0, x[22:0]};
		end else begin
			op.exp  = $signed({2'b00, x[30:23]}) - FMUL_EXP_BIAS;
			op.mant = {1'b1, x[22:0]};
		end
		return op;
	endfunction

	assign op_a = split(a);
	assign op_b = split(b);

	assign a_zero = (a[30:0] == 31'd0);
	assign b_zero = (b[30:0] == 31'd0);
	assign a_inf  = (a[30:23] == FMUL_EXP_ALL1) && (a[22:0] == 23'd0);
	assign b_inf  = (b[30:23] == FMUL_EXP_ALL1) && (b[22:0] == 23'd0);
	assign a_nan  = (a[30:23] == FMUL_EXP_ALL1) && (a[22:0] != 23'd0);
	assign b_nan  = (b[30:23] == FMUL_EXP_ALL1) && (b[22:0] != 23'd0);

	always_comb begin
		if (a_nan || b_nan)
			cls = CLS_NAN;
		else if ((a_inf && b_zero) || (b_inf && a_zero))
			cls = CLS_NAN; // Inf times zero
		else if (a_inf || b_inf)
			cls = CLS_INF;
		else if (a_zero || b_zero)
			cls = CLS_ZERO;
		else
			cls = CLS_NORMAL;
	end

	always_ff @(posedge clk or posedge round_bit) begin
		if (round_bit) begin
			out <= '0;
		end else begin
			out.valid <= in_valid;
			out.cls   <= cls;
			out.sign  <= op_a.sign ^ op_b.sign;
			out.a     <= op_a;
			out.b     <= op_b;
		end
	end

endmodule

`default_nettype wire

// ==== design/fmul_normalize.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_normalize (
	input  logic                   clk,
	input  logic                   round_bit,
	input  fmul_pkg::fmul_unpack_t in,
	output fmul_pkg::fmul_unpack_t out
);
	import fmul_pkg::*;

	fmul_unpack_t nxt;

	// Leading zeros of a 24-bit mantissa, 24 when all clear
	function automatic logic [4:0] lead_zeros(input logic [23:0] m);
		logic [4:0] n;
		n = 5'd24;
		for (int i = 0; i < 24; i++) begin
			if (m[i])
				n = 5'(23 - i); // Highest set bit wins
		end
		return n;
	endfunction

	function automatic fmul_operand_t norm_op(input fmul_operand_t op);
		fmul_operand_t res;
		logic [4:0] n;
		res = op;
		n   = lead_zeros(op.mant);
		if (!op.mant[23]) begin
			res.mant = op.mant << n;
			res.exp  = op.exp - $signed({5'b00000, n});
		end
		return res;
	endfunction

	always_comb begin
		nxt   = in;
		nxt.a = norm_op(in.a);
		nxt.b = norm_op(in.b);
	end

	always_ff @(posedge clk or posedge round_bit) begin
		if (round_bit)
			out <= '0;
		else
			out <= nxt;
	end

endmodule

`default_nettype wire

// ==== design/fmul_multiply.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_multiply (
	input  logic                   clk,
	input  logic                   round_bit,
	input  fmul_pkg::fmul_unpack_t in,
	output fmul_pkg::fmul_prod_t   out
);
	import fmul_pkg::*;

	logic signed [9:0] exp_sum;
	logic [47:0]       product;

	// Product of two 1.x mantissas has its point above bit 46, hence the +1
	assign exp_sum = in.a.exp + in.b.exp + 10'sd1;
	assign product = in.a.mant * in.b.mant;

	always_ff @(posedge clk or posedge round_bit) begin
		if (round_bit) begin
			out <= '0;
		end else begin
			out.valid <= in.valid;
			out.cls   <= in.cls;
			out.sign  <= in.sign;
			out.exp   <= exp_sum;
			out.mant  <= product;
		end
	end

endmodule

`default_nettype wire

// ==== design/fmul_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_round (
	input  logic                 clk,
	input  logic                 round_bit,
	input  fmul_pkg::fmul_prod_t in,
	output fmul_pkg::fmul_round_t out
);
	import fmul_pkg::*;

	logic [47:0]       m_norm;
	logic signed [9:0] e_norm;
	logic signed [9:0] under;
	logic [4:0]        sh;
	logic [47:0]       lost_mask;
	logic [47:0]       m_den;
	logic signed [9:0] e_den;
	logic              lost;
	logic [23:0]       m_top;
	logic              guard;
	logic              rnd;
	logic              sticky;
	logic              round_up;
	logic [24:0]       m_sum;
	fmul_round_t       nxt;

	// Product in [1,4), bring it to [1,2)
	always_comb begin
		if (in.mant[47]) begin
			m_norm = in.mant;
			e_norm = in.exp;
		end else begin
			m_norm = in.mant << 1;
			e_norm = in.exp - 10'sd1;
		end
	end

	// Denormalize below the smallest normal exponent
	assign under = FMUL_EXP_MIN - e_norm;

	always_comb begin
		if (e_norm >= FMUL_EXP_MIN)
			sh = 5'd0;
		else if (under > FMUL_DENORM_SHIFT_MAX)
			sh = FMUL_DENORM_SHIFT_MAX[4:0];
		else
			sh = under[4:0];
	end

	assign lost_mask = (48'd1 << sh) - 48'd1;
	assign lost      = |(m_norm & lost_mask); // Bits shifted out
	assign m_den     = m_norm >> sh;
	assign e_den     = (e_norm < FMUL_EXP_MIN) ? FMUL_EXP_MIN : e_norm;

	assign m_top    = m_den[47:24];
	assign guard    = m_den[23];
	assign rnd      = m_den[22];
	assign sticky   = (|m_den[21:0]) | lost;
	assign round_up = guard & (rnd | sticky | m_top[0]); // Nearest, ties to even
	assign m_sum    = {1'b0, m_top} + {24'd0, round_up};

	always_comb begin
		nxt.valid = in.valid;
		nxt.cls   = in.cls;
		nxt.sign  = in.sign;
		if (m_sum[24]) begin
			nxt.mant = m_sum[24:1]; // Carry out of rounding
			nxt.exp  = e_den + 10'sd1;
		end else begin
			nxt.mant = m_sum[23:0];
			nxt.exp  = e_den;
		end
	end

	always_ff @(posedge clk or posedge round_bit) begin
		if (round_bit)
			out <= '0;
		else
			out <= nxt;
	end

endmodule

`default_nettype wire

// ==== design/fmul_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_pack (
	input  logic                  clk,
	input  logic                  round_bit,
	input  fmul_pkg::fmul_round_t in,
	output logic                  out_valid,
	output logic [31:0]           z
);
	import fmul_pkg::*;

	logic signed [9:0] exp_biased;
	logic [31:0]       z_nxt;

	assign exp_biased = in.exp + FMUL_EXP_BIAS;

	always_comb begin
		case (in.cls)
			CLS_NAN:  z_nxt = FMUL_QNAN;
			CLS_INF:  z_nxt = {in.sign, FMUL_EXP_ALL1, 23'd0};
			CLS_ZERO: z_nxt = {in.sign, 31'd0};
			default: begin
				if (in.exp > FMUL_EXP_MAX)
					z_nxt = {in.sign, FMUL_EXP_ALL1, 23'd0}; // Overflow
				else if (in.exp == FMUL_EXP_MIN && !in.mant[23])
					z_nxt = {in.sign, 8'd0, in.mant[22:0]}; // Subnormal or zero
				else
					z_nxt = {in.sign, exp_biased[7:0], in.mant[22:0]};
			end
		endcase
	end

	always_ff @(posedge clk or posedge round_bit) begin
		if (round_bit) begin
			out_valid <= 1'b0;
			z         <= 32'd0;
		end else begin
			out_valid <= in.valid;
			z         <= z_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== design/fmul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_top (
	input  logic        clk,
	input  logic        round_bit,
	input  logic        in_valid,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic        out_valid,
	output logic [31:0] z
);
	import fmul_pkg::*;

	fmul_unpack_t unpack_q;
	fmul_unpack_t norm_q;
	fmul_prod_t   prod_q;
	fmul_round_t  round_q;

	fmul_unpack i_unpack (
		.clk       (clk),
		.round_bit (round_bit),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out       (unpack_q)
	);

	fmul_normalize i_normalize (
		.clk       (clk),
		.round_bit (round_bit),
		.in        (unpack_q),
		.out       (norm_q)
	);

	fmul_multiply i_multiply (
		.clk       (clk),
		.round_bit (round_bit),
		.in        (norm_q),
		.out       (prod_q)
	);

	fmul_round i_round (
		.clk       (clk),
		.round_bit (round_bit),
		.in        (prod_q),
		.out       (round_q)
	);

	fmul_pack i_pack (
		.clk       (clk),
		.round_bit (round_bit),
		.in        (round_q),
		.out_valid (out_valid),
		.z         (z)
	);

endmodule

`default_nettype wire

// ==== tests/fmul_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_clock_gen (
	output logic clk,
	output logic round_bit
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		round_bit = 1'b1;
		repeat (8) @(posedge clk);
		round_bit <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/fmul_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_assertions (
	input logic        clk,
	input logic        round_bit,
	input logic        in_valid,
	input logic        out_valid,
	input logic [31:0] z
);

	a_quiet_in_reset: assert property (@(posedge clk) round_bit |-> !out_valid)
		else $error("out_valid high while reset is active");

	// Five registered stages
	a_latency: assert property (@(posedge clk) disable iff (round_bit)
		out_valid == $past(in_valid, 5))
		else $error("out_valid does not follow in_valid by 5 cycles");

	a_z_known: assert property (@(posedge clk) disable iff (round_bit)
		out_valid |-> !$isunknown(z))
		else $error("z unknown while out_valid is high");

endmodule

bind fmul_top fmul_assertions i_assertions (.*);

`default_nettype wire

// ==== tests/fmul_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_tb;

	localparam int N_NORM  = 100;
	localparam int N_SUB   = 40;
	localparam int N_OVF   = 20;
	localparam int N_GAP   = 100;
	localparam int N_FIXED = 19;
	localparam int N_OPS   = N_NORM + 2 * N_SUB + N_OVF + N_GAP + N_FIXED;
	localparam int N_IDLE  = 3 * N_GAP + 40; // Random gaps, reset, drain
	localparam int TIMEOUT_CYCLES = (N_OPS + N_IDLE) * 2 + 100;

	logic        clk;
	logic        round_bit;
	logic        in_valid;
	logic [31:0] a;
	logic [31:0] b;
	logic        out_valid;
	logic [31:0] z;

	logic [31:0] expected[$];
	logic [4:0]  valid_hist;
	int          sent;
	int          received;
	int          cycles;

	fmul_clock_gen i_clock_gen (.clk(clk), .round_bit(round_bit));

	fmul_top i_fmul_top (
		.clk       (clk),
		.round_bit (round_bit),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.z         (z)
	);

	// Exact integer product, rounded to nearest even
	function automatic logic [31:0] ref_fmul(input logic [31:0] x, input logic [31:0] y);
		logic sgn, x_nan, y_nan, x_inf, y_inf, x_zero, y_zero;
		int ex, ey, k, t, r, i;
		longint unsigned mx, my, p, keep, rem, half;
		sgn    = x[31] ^ y[31];
		x_nan  = (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
		y_nan  = (y[30:23] == 8'hFF) && (y[22:0] != 23'd0);
		x_inf  = (x[30:23] == 8'hFF) && (x[22:0] == 23'd0);
		y_inf  = (y[30:23] == 8'hFF) && (y[22:0] == 23'd0);
		x_zero = (x[30:0] == 31'd0);
		y_zero = (y[30:0] == 31'd0);
		if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero))
			return 32'hFFC00000;
		if (x_inf || y_inf)
			return {sgn, 8'hFF, 23'd0};
		if (x_zero || y_zero)
			return {sgn, 31'd0};
		ex = (x[30:23] == 8'd0) ? -126 : int'(x[30:23]) - 127;
		ey = (y[30:23] == 8'd0) ? -126 : int'(y[30:23]) - 127;
		mx = (x[30:23] == 8'd0) ? x[22:0] : {1'b1, x[22:0]};
		my = (y[30:23] == 8'd0) ? y[22:0] : {1'b1, y[22:0]};
		p  = mx * my; // Worth p * 2^(ex + ey - 46)
		k  = 0;
		for (i = 0; i < 48; i++)
			if (p[i])
				k = i;
		t = ex + ey - 46 + k;
		if (t < -126)
			t = -126; // Subnormal range
		r = t - 23 - (ex + ey - 46); // Right shift to a 24-bit mantissa
		if (r <= 0) begin
			keep = p << (-r);
		end else if (r > 60) begin
			keep = 0;
		end else begin
			keep = p >> r;
			rem  = p & ((64'd1 << r) - 64'd1);
			half = 64'd1 << (r - 1);
			if (rem > half || (rem == half && keep[0]))
				keep++;
		end
		if (keep == (64'd1 << 24)) begin
			keep = keep >> 1;
			t++;
		end
		if (t > 127)
			return {sgn, 8'hFF, 23'd0};
		if (keep < (64'd1 << 23))
			return {sgn, 8'd0, keep[22:0]};
		return {sgn, 8'(t + 127), keep[22:0]};
	endfunction

	function automatic logic [31:0] rand_float(input int exp_lo, input int exp_hi);
		logic [31:0] f;
		f[31]    = 1'($urandom);
		f[30:23] = 8'($urandom_range(exp_hi, exp_lo));
		f[22:0]  = 23'($urandom);
		return f;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_z(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("** Error: z = %08h, expected %08h", got, exp));
	endtask

	task automatic check_out_valid(input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("** Error: out_valid = %0h, expected %0h", got, exp));
	endtask

	task automatic check_valid_count(input int got, input int exp);
		if (got != exp)
			stop_with_failure($sformatf("** Error: out_valid count = %0h, expected %0h",
				got, exp));
	endtask

	task automatic send(input logic [31:0] x, input logic [31:0] y);
		@(posedge clk);
		in_valid <= 1'b1;
		a        <= x;
		b        <= y;
		expected.push_back(ref_fmul(x, y));
		sent++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (round_bit) begin
			if (out_valid)
				stop_with_failure("out_valid went high during reset");
		end else begin
			check_out_valid(out_valid, valid_hist[4]); // Five stages of latency
			if (out_valid) begin
				if (expected.size() == 0)
					stop_with_failure("A result came out with no input waiting for it");
				check_z(z, expected.pop_front());
				received++;
			end
		end
		valid_hist = {valid_hist[3:0], in_valid};
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			stop_with_failure($sformatf("Timeout: run not finished after %0d cycles", cycles));
	end

	initial begin
		void'($urandom(32'h9921f1b3));
		in_valid   = 1'b0;
		a          = 32'd0;
		b          = 32'd0;
		valid_hist = 5'd0;
		@(negedge round_bit);
		idle(2);

		send(32'h3FC00000, 32'h3F800001); // Ties, odd and even
		send(32'h3FC00000, 32'h3F800003);
		send(32'hC0400000, 32'h41000001);
		send(32'h3FC00000, 32'hBF800005);
		idle(2);

		send(32'h7FC00001, 32'h3F800000);
		send(32'h3F800000, 32'hFF800001);
		send(32'h7F800000, 32'h00000000); // Inf times zero
		send(32'h80000000, 32'hFF800000);
		send(32'h7F800000, 32'hC0000000);
		send(32'hFF800000, 32'hFF800000);
		send(32'h00000000, 32'hC0490FDB);
		send(32'h80000000, 32'h80000000);
		send(32'h80000000, 32'h00000001);
		send(32'h7FC00000, 32'h7F800000);
		idle(2);

		send(32'h7F7FFFFE, 32'h3F800001); // Carry into overflow
		send(32'hFF7FFFFE, 32'h3F800001);
		send(32'h7F7FFFFF, 32'h3F800000);
		send(32'h00000001, 32'h00000001);
		send(32'h00000001, 32'h4B000000);
		idle(2);

		repeat (N_NORM) send(rand_float(64, 190), rand_float(64, 190));
		repeat (N_SUB) send(rand_float(0, 0), rand_float(100, 200));
		repeat (N_SUB) send(rand_float(30, 80), rand_float(30, 80));
		repeat (N_OVF) send(rand_float(200, 254), rand_float(200, 254));
		idle(2);

		repeat (N_GAP) begin
			idle($urandom_range(3, 0));
			send(rand_float(1, 254), rand_float(1, 254));
		end
		idle(1);

		idle(10); // Well past the fixed latency
		check_valid_count(received, sent);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
design/fmul_pkg.sv
design/fmul_unpack.sv
design/fmul_normalize.sv
design/fmul_multiply.sv
design/fmul_round.sv
design/fmul_pack.sv
design/fmul_top.sv
tests/fmul_clock_gen.sv
tests/fmul_assertions.sv
tests/fmul_tb.sv

// ==== Bender.yml ====
package:
  name: fmul

sources:
  - files:
      - design/fmul_pkg.sv
      - design/fmul_unpack.sv
      - design/fmul_normalize.sv
      - design/fmul_multiply.sv
      - design/fmul_round.sv
      - design/fmul_pack.sv
      - design/fmul_top.sv
  - target: test
    files:
      - tests/fmul_clock_gen.sv
      - tests/fmul_assertions.sv
      - tests/fmul_tb.sv
